// File: all.f
+incdir+hdl
hdl/bus_pkg.sv
hdl/video_pkg.sv
hdl/mem_bus_if.sv
hdl/crtc.sv
hdl/video_fetch.sv
hdl/dotgen.sv
hdl/bus_arbiter.sv
hdl/pet_video_top.sv
testbench/tb_pet_video.sv

// File: testbench/tb_pet_video.sv
// pet video testbench
`default_nettype none
`timescale 1ns/10ps
`include "video_defines.svh"

module tb_pet_video;

    localparam int LINE_CYCLES  = `H_TOTAL * `DOTS;
    localparam int FRAME_LINES  = `V_TOTAL * `SCAN_LINES;
    localparam int FRAME_CYCLES = FRAME_LINES * LINE_CYCLES;
    localparam int CELLS        = `CHAR_COLS * `CHAR_ROWS;
    // loading at up to 8 cycles per access, up to a frame to find vsync, two frames checked
    localparam int TIMEOUT_CYCLES = 8 * (CELLS + `CHRAM_SIZE + 64) + 3 * FRAME_CYCLES + 10000;

    logic        clk;
    logic        reset;
    logic        cpu_req;
    logic        cpu_we;
    logic [13:0] cpu_addr;
    logic [7:0]  cpu_wdata;
    logic [7:0]  cpu_rdata;
    logic        cpu_ack;
    logic        h_sync;
    logic        v_sync;
    logic        video;

    // reference copy of both memories
    logic [7:0]  vram_mirror [CELLS];
    logic [7:0]  chram_mirror [`CHRAM_SIZE];
    int          seed;
    longint      cycle_cnt;
    longint      h_rise;
    longint      v_rise;
    logic        hs_prev;
    logic        vs_prev;
    bit          watch_armed;
    bit          watching;
    bit          frames_done;
    int          t_watch;

    pet_video_top i_dut (
        .pixel_clk_i (clk),
        .reset_i     (reset),
        .cpu_req_i   (cpu_req),
        .cpu_we_i    (cpu_we),
        .cpu_addr_i  (cpu_addr),
        .cpu_wdata_i (cpu_wdata),
        .cpu_rdata_o (cpu_rdata),
        .cpu_ack_o   (cpu_ack),
        .h_sync_o    (h_sync),
        .v_sync_o    (v_sync),
        .video_o     (video)
    );

    always #2 clk = ~clk;

    task automatic report_error(input string msg);
        $display("[ERROR] %0t %s", $time, msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "check failed");
    endtask

    // one bus cycle, req held until the ack pulse
    task automatic cpu_access(input logic we, input logic [13:0] addr,
                              input logic [7:0] wdata, output logic [7:0] rdata);
        @(posedge clk);
        cpu_req   <= 1'b1;
        cpu_we    <= we;
        cpu_addr  <= addr;
        cpu_wdata <= wdata;
        @(negedge clk);
        while (!cpu_ack) @(negedge clk);
        rdata = cpu_rdata;
        @(posedge clk);
        cpu_req <= 1'b0;
        cpu_we  <= 1'b0;
    endtask

    task automatic cpu_read_check(input logic [13:0] addr, input logic [7:0] exp);
        logic [7:0] rd;
        cpu_access(1'b0, addr, 8'h00, rd);
        assert (rd === exp) else
            report_error($sformatf("read of %h returned %h, expected %h", addr, rd, exp));
    endtask

    // pixel t cycles after the vsync rise, which is column 42 of sync row 28
    function automatic logic expected_pixel(input int t);
        int         u;
        int         n;
        int         c;
        int         d;
        int         rs;
        logic [7:0] code;
        logic [7:0] glyph;
        u  = t + `H_SYNC_START * `DOTS;
        n  = u / LINE_CYCLES;
        c  = (u % LINE_CYCLES) / `DOTS;
        d  = u % `DOTS;
        // first lines after the rise are the bottom rows of the old frame
        rs = (n + FRAME_LINES - (`V_TOTAL - `V_SYNC_START) * `SCAN_LINES) % FRAME_LINES;
        if ((rs / `SCAN_LINES) >= `CHAR_ROWS || c >= `CHAR_COLS) begin
            return 1'b0;
        end
        code  = vram_mirror[(rs / `SCAN_LINES) * `CHAR_COLS + c];
        glyph = chram_mirror[code[6:0] * `SCAN_LINES + rs % `SCAN_LINES];
        return glyph[7 - d] ^ code[7];
    endfunction

    a_low_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> (!h_sync && !v_sync && !video && !cpu_ack))
        else report_error("outputs not low after reset");
    // single cycle ack, only against a live request
    a_ack_pulse: assert property (@(posedge clk) disable iff (reset) cpu_ack |=> !cpu_ack)
        else report_error("cpu ack longer than one cycle");
    a_ack_with_req: assert property (@(posedge clk) disable iff (reset) cpu_ack |-> cpu_req)
        else report_error("cpu ack without a request");
    a_vs_with_hs: assert property (@(posedge clk) disable iff (reset)
        $rose(v_sync) |-> $rose(h_sync))
        else report_error("v_sync rose apart from h_sync");

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout elapsed after %0d cycles before the frame checks ended", cycle_cnt);
            $display("TESTBENCH FAILED");
            $fatal(1, "timeout");
        end
    end

    // sync timing and pixels, sampled mid-cycle
    always @(negedge clk) begin
        if (reset) begin
            hs_prev = 1'b0;
            vs_prev = 1'b0;
            h_rise  = -1;
            v_rise  = -1;
        end else begin
            if (h_sync && !hs_prev) begin
                if (h_rise >= 0) assert (cycle_cnt - h_rise == LINE_CYCLES) else
                    report_error($sformatf("h_sync period %0d", cycle_cnt - h_rise));
                h_rise = cycle_cnt;
            end
            if (!h_sync && hs_prev) assert (cycle_cnt - h_rise == `H_SYNC_WIDTH * `DOTS) else
                report_error($sformatf("h_sync width %0d", cycle_cnt - h_rise));
            if (v_sync && !vs_prev) begin
                if (v_rise >= 0) assert (cycle_cnt - v_rise == FRAME_CYCLES) else
                    report_error($sformatf("v_sync period %0d", cycle_cnt - v_rise));
                v_rise = cycle_cnt;
                // T0 of the checked window
                if (watch_armed && !watching && !frames_done) begin
                    watching = 1'b1;
                    t_watch  = 0;
                end
            end
            if (!v_sync && vs_prev) begin
                assert (cycle_cnt - v_rise == `V_SYNC_WIDTH * `SCAN_LINES * LINE_CYCLES) else
                    report_error($sformatf("v_sync width %0d", cycle_cnt - v_rise));
            end
            if (watching) begin
                assert (video === expected_pixel(t_watch)) else
                    report_error($sformatf("video_o %b at %0d cycles after vsync, expected %b",
                                           video, t_watch, expected_pixel(t_watch)));
                t_watch++;
                if (t_watch == 2 * FRAME_CYCLES) begin
                    watching    = 1'b0;
                    frames_done = 1'b1;
                end
            end
            hs_prev = h_sync;
            vs_prev = v_sync;
        end
    end

    initial begin
        logic [7:0] rd;
        int         idx;
        seed        = 32'hfced;
        clk         = 1'b0;
        reset       = 1'b1;
        cpu_req     = 1'b0;
        cpu_we      = 1'b0;
        cpu_addr    = '0;
        cpu_wdata   = '0;
        cycle_cnt   = 0;
        watch_armed = 1'b0;
        watching    = 1'b0;
        frames_done = 1'b0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        // screen codes, then glyph rows
        for (int i = 0; i < CELLS; i++) begin
            vram_mirror[i] = $random(seed);
            cpu_access(1'b1, `VRAM_BASE + 14'(i), vram_mirror[i], rd);
        end
        for (int i = 0; i < `CHRAM_SIZE; i++) begin
            chram_mirror[i] = $random(seed);
            cpu_access(1'b1, `CHRAM_BASE + 14'(i), chram_mirror[i], rd);
        end
        for (int i = 0; i < 16; i++) begin
            idx = ($random(seed) & 32'h7fffffff) % CELLS;
            cpu_read_check(`VRAM_BASE + 14'(idx), vram_mirror[idx]);
            idx = ($random(seed) & 32'h7fffffff) % `CHRAM_SIZE;
            cpu_read_check(`CHRAM_BASE + 14'(idx), chram_mirror[idx]);
        end
        // top of the map decodes to nothing
        cpu_read_check(14'h3fff, 8'hff);
        watch_armed = 1'b1;
        // cpu keeps reading while video owns its slots
        while (!frames_done) begin
            idx = ($random(seed) & 32'h7fffffff) % (CELLS + `CHRAM_SIZE);
            if (idx < CELLS) begin
                cpu_read_check(`VRAM_BASE + 14'(idx), vram_mirror[idx]);
            end else begin
                cpu_read_check(`CHRAM_BASE + 14'(idx - CELLS), chram_mirror[idx - CELLS]);
            end
            repeat ($random(seed) & 7) @(posedge clk);
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/pet_video_top.sv
// pet character video top level
`default_nettype none
`timescale 1ns/10ps

module pet_video_top (
    input  wire logic        pixel_clk_i,
    input  wire logic        reset_i,
    input  wire logic        cpu_req_i,
    input  wire logic        cpu_we_i,
    input  wire logic [13:0] cpu_addr_i,
    input  wire logic [7:0]  cpu_wdata_i,
    output logic [7:0]       cpu_rdata_o,
    output logic             cpu_ack_o,
    output logic             h_sync_o,
    output logic             v_sync_o,
    output logic             video_o
);
    import video_pkg::*;

    logic       cclk_en;
    logic       vram_slot;
    logic       chram_slot;
    logic       hs;
    logic       vs;
    logic       de;
    ma_t        ma;
    ra_t        ra;
    logic [7:0] pixels;
    logic       reverse;
    logic       de_q;

    mem_bus_if vid_bus ();
    mem_bus_if cpu_bus ();

    // cpu side comes straight from the pins
    assign cpu_bus.req   = cpu_req_i;
    assign cpu_bus.we    = cpu_we_i;
    assign cpu_bus.addr  = cpu_addr_i;
    assign cpu_bus.wdata = cpu_wdata_i;
    assign cpu_rdata_o   = cpu_bus.rdata;
    assign cpu_ack_o     = cpu_bus.ack;

    crtc i_crtc (
        .pixel_clk_i  (pixel_clk_i),
        .reset_i      (reset_i),
        .cclk_en_o    (cclk_en),
        .vram_slot_o  (vram_slot),
        .chram_slot_o (chram_slot),
        .h_sync_o     (hs),
        .v_sync_o     (vs),
        .de_o         (de),
        .ma_o         (ma),
        .ra_o         (ra)
    );

    video_fetch i_video_fetch (
        .pixel_clk_i  (pixel_clk_i),
        .reset_i      (reset_i),
        .cclk_en_i    (cclk_en),
        .vram_slot_i  (vram_slot),
        .chram_slot_i (chram_slot),
        .h_sync_i     (hs),
        .v_sync_i     (vs),
        .de_i         (de),
        .ma_i         (ma),
        .ra_i         (ra),
        .bus          (vid_bus.requester),
        .pixels_o     (pixels),
        .reverse_o    (reverse),
        .de_o         (de_q),
        .h_sync_o     (h_sync_o),
        .v_sync_o     (v_sync_o)
    );

    // glyph row loads on the character clock
    dotgen i_dotgen (
        .pixel_clk_i  (pixel_clk_i),
        .reset_i      (reset_i),
        .load_i       (cclk_en),
        .pixels_i     (pixels),
        .reverse_i    (reverse),
        .display_en_i (de_q),
        .video_o      (video_o)
    );

    bus_arbiter i_bus_arbiter (
        .pixel_clk_i (pixel_clk_i),
        .reset_i     (reset_i),
        .vid         (vid_bus.arbiter),
        .cpu         (cpu_bus.arbiter)
    );

endmodule

`default_nettype wire

// File: hdl/bus_arbiter.sv
// fixed-priority arbiter and shared video memory
`default_nettype none
`timescale 1ns/10ps
`include "video_defines.svh"

module bus_arbiter (
    input  wire logic  pixel_clk_i,
    input  wire logic  reset_i,
    mem_bus_if.arbiter vid,
    mem_bus_if.arbiter cpu
);
    import bus_pkg::*;
    import video_pkg::*;

    bus_data_t   vram [`VRAM_SIZE];
    bus_data_t   chram [`CHRAM_SIZE];
    requester_t  owner_q;
    logic        busy_q;
    bus_data_t   rdata_q;
    logic        vid_ack;
    logic        cpu_ack;
    logic        grant_vid;
    logic        grant_cpu;
    logic        sel_we;
    bus_data_t   sel_wdata;
    fetch_addr_u addr_u;
    logic        in_vram;
    logic        in_chram;

    // ack in the cycle after the grant
    assign vid_ack = busy_q && (owner_q == REQ_VIDEO);
    assign cpu_ack = busy_q && (owner_q == REQ_CPU);

    // a req in its ack cycle is already served
    assign grant_vid = vid.req && !vid_ack;
    assign grant_cpu = cpu.req && !cpu_ack && !grant_vid;

    assign addr_u    = grant_vid ? vid.addr : cpu.addr;
    assign sel_we    = grant_vid ? vid.we : cpu.we;
    assign sel_wdata = grant_vid ? vid.wdata : cpu.wdata;

    // region from the upper address bits
    assign in_vram  = (addr_u.vram_addr.zero == 4'(`VRAM_BASE >> 10));
    assign in_chram = (addr_u.glyph_addr.tag == 2'(`CHRAM_BASE >> 12)) &&
                      (addr_u.glyph_addr.pad == 2'b00);

    always_ff @(posedge pixel_clk_i) begin
        if (reset_i) begin
            busy_q  <= 1'b0;
            owner_q <= REQ_VIDEO;
        end else begin
            busy_q  <= grant_vid | grant_cpu;
            owner_q <= grant_vid ? REQ_VIDEO : REQ_CPU;
        end
    end

    // one access per cycle
    // a write reads back the old byte
    always_ff @(posedge pixel_clk_i) begin
        if ((grant_vid | grant_cpu) && sel_we) begin
            if (in_vram) begin
                vram[addr_u.vram_addr.ma] <= sel_wdata;
            end else if (in_chram) begin
                chram[{addr_u.glyph_addr.glyph, addr_u.glyph_addr.ra}] <= sel_wdata;
            end
        end
        if (in_vram) begin
            rdata_q <= vram[addr_u.vram_addr.ma];
        end else if (in_chram) begin
            rdata_q <= chram[{addr_u.glyph_addr.glyph, addr_u.glyph_addr.ra}];
        end else begin
            // open bus
            rdata_q <= 8'hff;
        end
    end

    assign vid.rdata = rdata_q;
    assign cpu.rdata = rdata_q;
    assign vid.ack   = vid_ack;
    assign cpu.ack   = cpu_ack;

    a_one_ack: assert property (@(posedge pixel_clk_i) disable iff (reset_i)
        !(vid.ack && cpu.ack));

    // video slots never stall
    a_vid_next: assert property (@(posedge pixel_clk_i) disable iff (reset_i)
        (vid.req && !vid.ack) |=> vid.ack);

endmodule

`default_nettype wire

// File: hdl/dotgen.sv
// dot shifter with reverse video
`default_nettype none
`timescale 1ns/10ps

module dotgen (
    input  wire logic       pixel_clk_i,
    input  wire logic       reset_i,
    input  wire logic       load_i,
    input  wire logic [7:0] pixels_i,
    input  wire logic       reverse_i,
    input  wire logic       display_en_i,
    output logic            video_o
);
    logic [7:0] shift_q;
    logic       reverse_q;

    always_ff @(posedge pixel_clk_i) begin
        if (reset_i) begin
            shift_q   <= '0;
            reverse_q <= 1'b0;
        end else if (load_i) begin
            // reverse bit kept for the whole cell
            shift_q   <= pixels_i;
            reverse_q <= reverse_i;
        end else begin
            // msb is the leftmost dot
            shift_q <= {shift_q[6:0], 1'b0};
        end
    end

    // blanked outside the visible area
    assign video_o = display_en_i & (shift_q[7] ^ reverse_q);

endmodule

`default_nettype wire

// File: hdl/video_fetch.sv
// character and glyph fetch sequencer
`default_nettype none
`timescale 1ns/10ps
`include "video_defines.svh"

module video_fetch (
    input  wire logic           pixel_clk_i,
    input  wire logic           reset_i,
    input  wire logic           cclk_en_i,
    input  wire logic           vram_slot_i,
    input  wire logic           chram_slot_i,
    input  wire logic           h_sync_i,
    input  wire logic           v_sync_i,
    input  wire logic           de_i,
    input  wire video_pkg::ma_t ma_i,
    input  wire video_pkg::ra_t ra_i,
    mem_bus_if.requester        bus,
    output logic [7:0]          pixels_o,
    output logic                reverse_o,
    output logic                de_o,
    output logic                h_sync_o,
    output logic                v_sync_o
);
    import bus_pkg::*;
    import video_pkg::*;

    char_code_t  char_q;
    bus_data_t   glyph_q;
    fetch_addr_u addr_u;
    logic        pend_q;
    logic        glyph_pend_q;
    logic        glyph_sel;

    // glyph cycle from its slot until acked
    assign glyph_sel = chram_slot_i | glyph_pend_q;

    always_comb begin
        addr_u = '0;
        if (glyph_sel) begin
            // glyph of the code latched in the first slot
            addr_u.glyph_addr.tag   = 2'(`CHRAM_BASE >> 12);
            addr_u.glyph_addr.glyph = char_q.glyph;
            addr_u.glyph_addr.ra    = ra_i;
        end else begin
            addr_u.vram_addr.zero = 4'(`VRAM_BASE >> 10);
            addr_u.vram_addr.ma   = ma_i;
        end
    end

    // read only port, req held past the slot until ack
    assign bus.req   = vram_slot_i | chram_slot_i | pend_q;
    assign bus.we    = 1'b0;
    assign bus.addr  = addr_u;
    assign bus.wdata = '0;

    always_ff @(posedge pixel_clk_i) begin
        if (reset_i) begin
            pend_q       <= 1'b0;
            glyph_pend_q <= 1'b0;
            h_sync_o     <= 1'b0;
            v_sync_o     <= 1'b0;
            de_o         <= 1'b0;
        end else begin
            pend_q       <= bus.req & ~bus.ack;
            glyph_pend_q <= glyph_sel & ~bus.ack;
            // syncs leave with the pixels of this cell
            if (cclk_en_i) begin
                h_sync_o <= h_sync_i;
                v_sync_o <= v_sync_i;
                de_o     <= de_i;
            end
        end
    end

    // code at phase 1, glyph row at phase 3
    always_ff @(posedge pixel_clk_i) begin
        if (bus.ack) begin
            if (glyph_sel) begin
                glyph_q <= bus.rdata;
            end else begin
                char_q <= bus.rdata;
            end
        end
    end

    assign pixels_o  = glyph_q;
    assign reverse_o = char_q.reverse;

    a_ack_in_req: assert property (@(posedge pixel_clk_i) disable iff (reset_i)
        bus.ack |-> bus.req);

endmodule

`default_nettype wire

// File: hdl/crtc.sv
// character timing generator
`default_nettype none
`timescale 1ns/10ps
`include "video_defines.svh"

module crtc (
    input  wire logic       pixel_clk_i,
    input  wire logic       reset_i,
    output logic            cclk_en_o,
    output logic            vram_slot_o,
    output logic            chram_slot_o,
    output logic            h_sync_o,
    output logic            v_sync_o,
    output logic            de_o,
    output video_pkg::ma_t  ma_o,
    output video_pkg::ra_t  ra_o
);
    import video_pkg::*;

    logic [2:0]  phase_q;
    logic [5:0]  col_q;
    ra_t         scan_q;
    logic [4:0]  row_q;
    logic        vs_q;
    logic        vram_slot_q;
    logic        chram_slot_q;
    logic        col_last;
    logic        scan_last;
    logic        row_last;
    logic [10:0] ma_full;

    // last dot of the cell, counters step here
    assign cclk_en_o = (phase_q == `DOTS - 1);
    assign col_last  = (col_q == `H_TOTAL - 1);
    assign scan_last = (scan_q == `SCAN_LINES - 1);
    assign row_last  = (row_q == `V_TOTAL - 1);

    always_ff @(posedge pixel_clk_i) begin
        if (reset_i) begin
            phase_q      <= '0;
            col_q        <= '0;
            scan_q       <= '0;
            row_q        <= '0;
            vs_q         <= 1'b0;
            vram_slot_q  <= 1'b0;
            chram_slot_q <= 1'b0;
        end else begin
            phase_q <= cclk_en_o ? 3'd0 : phase_q + 3'd1;
            // strobes registered so they land in phase 0 and phase 2
            vram_slot_q  <= cclk_en_o;
            chram_slot_q <= (phase_q == 3'd1);
            if (cclk_en_o) begin
                if (col_last) begin
                    col_q <= '0;
                    if (scan_last) begin
                        scan_q <= '0;
                        row_q  <= row_last ? 5'd0 : row_q + 5'd1;
                    end else begin
                        scan_q <= scan_q + 3'd1;
                    end
                end else begin
                    col_q <= col_q + 6'd1;
                end
                // vsync only changes as hsync starts
                if (col_q == `H_SYNC_START - 1) begin
                    vs_q <= (row_q >= `V_SYNC_START) &&
                            (row_q < `V_SYNC_START + `V_SYNC_WIDTH);
                end
            end
        end
    end

    assign vram_slot_o  = vram_slot_q;
    assign chram_slot_o = chram_slot_q;
    assign h_sync_o = (col_q >= `H_SYNC_START) && (col_q < `H_SYNC_START + `H_SYNC_WIDTH);
    assign v_sync_o = vs_q;
    assign de_o     = (col_q < `CHAR_COLS) && (row_q < `CHAR_ROWS);

    // row * 40 + col, wide enough for the blanked cells too
    assign ma_full = 11'(row_q * `CHAR_COLS) + 11'(col_q);
    assign ma_o    = ma_full[9:0];
    assign ra_o    = scan_q;

    // visible cells never run past video RAM
    a_ma_in_vram: assert property (@(posedge pixel_clk_i) disable iff (reset_i)
        de_o |-> (ma_full < `VRAM_SIZE));

endmodule

`default_nettype wire

// File: hdl/mem_bus_if.sv
// one requester port on the shared memory bus
`default_nettype none
`timescale 1ns/10ps

interface mem_bus_if;
    import bus_pkg::*;

    // request level, held with its fields until ack
    logic      req;
    logic      we;
    bus_addr_t addr;
    bus_data_t wdata;

    // single-cycle ack, rdata valid with it
    bus_data_t rdata;
    logic      ack;

    modport requester (
        output req, we, addr, wdata,
        input  rdata, ack
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output rdata, ack
    );

endinterface

`default_nettype wire

// File: hdl/video_pkg.sv
// video timing and fetch address types
`default_nettype none

package video_pkg;

    // matrix address, one per screen cell
    typedef logic [9:0] ma_t;

    // row address, scan line inside a character row
    typedef logic [2:0] ra_t;

    // bit 7 selects reverse video
    typedef struct packed {
        logic       reverse;
        logic [6:0] glyph;
    } char_code_t;

    // screen cell in video RAM
    typedef struct packed {
        logic [3:0] zero;
        ma_t        ma;
    } vram_addr_t;

    // glyph row in character RAM, tag 2'b10 marks the region
    typedef struct packed {
        logic [1:0] tag;
        logic [1:0] pad;
        logic [6:0] glyph;
        ra_t        ra;
    } glyph_addr_t;

    // one bus address, two readings
    typedef union packed {
        vram_addr_t  vram_addr;
        glyph_addr_t glyph_addr;
    } fetch_addr_u;

endpackage

`default_nettype wire

// File: hdl/bus_pkg.sv
// shared memory bus types
`default_nettype none

package bus_pkg;

    // 16 KB window seen by both requesters
    typedef logic [13:0] bus_addr_t;

    // one byte per access
    typedef logic [7:0] bus_data_t;

    // who owns the memory cycle
    // video first so it reads as the priority side
    typedef enum logic {
        REQ_VIDEO,
        REQ_CPU
    } requester_t;

endpackage

`default_nettype wire

// File: hdl/video_defines.svh
// video geometry and memory map
`ifndef VIDEO_DEFINES_SVH
`define VIDEO_DEFINES_SVH

// horizontal timing, in character times
`define CHAR_COLS     40
`define H_TOTAL       50
`define H_SYNC_START  42
`define H_SYNC_WIDTH  4

// vertical timing, in character rows
`define CHAR_ROWS     25
`define V_TOTAL       32
`define V_SYNC_START  28
`define V_SYNC_WIDTH  2

// cell size
`define SCAN_LINES    8
`define DOTS          8

// shared memory map, byte addresses on the 14-bit bus
`define VRAM_BASE     14'h0000
`define VRAM_SIZE     1024
`define CHRAM_BASE    14'h2000
`define CHRAM_SIZE    1024

`endif
